// File: Bender.yml
package:
  name: sine_filt

sources:
  - include_dirs:
      - source
    files:
      - source/fir_sample_pkg.sv
      - source/fir_cfg_pkg.sv
      - source/fir_delay_line.sv
      - source/fir_coef_bank.sv
      - source/fir_mac_tree.sv
      - source/sine_filt_top.sv
  - target: test
    include_dirs:
      - source
      - tb
    files:
      - tb/sine_filt_tb.sv

// File: source/fir_cfg_pkg.sv
`include "fir_params.svh"

package fir_cfg_pkg;

	// bit 31 tells the two word formats apart
	localparam logic CFG_TAG_MODE  = 1'b0;
	localparam logic CFG_TAG_WRITE = 1'b1;

	// bank numbering for writes and for the active select
	localparam logic BANK_A = 1'b0;
	localparam logic BANK_B = 1'b1;

	// coefficient write
	// loads one entry of either bank, active or not
	typedef struct packed {
		logic                          tag;
		logic                          bank;
		logic [3:0]                    index;
		logic [7:0]                    unused;
		logic signed [`FIR_DATA_W-1:0] value;
	} cfg_write_t;

	// mode word, picks the bank feeding the multipliers
	typedef struct packed {
		logic        tag;
		logic        bank_sel;
		logic [29:0] unused;
	} cfg_mode_t;

	// same 32 bits, read through whichever view the tag names
	typedef union packed {
		cfg_write_t wr;
		cfg_mode_t  mode;
	} cfg_word_u;

endpackage

// File: source/fir_coef_bank.sv
`timescale 1ns/1ps
`include "fir_params.svh"

module fir_coef_bank (
	input  logic                      clk,
	input  logic                      reset,
	input  fir_cfg_pkg::cfg_word_u    cfg_word,
	input  logic                      cfg_valid,
	output fir_sample_pkg::coef_set_t coefs
);
	import fir_sample_pkg::*;
	import fir_cfg_pkg::*;

	// first coefficient set, outer taps first
	localparam coef_t SET_A [`FIR_COEFS] = '{
		18'sd4090, 18'sd5895, 18'sd3323, -18'sd3446,
		-18'sd10669, -18'sd12449, -18'sd4025, 18'sd14901,
		18'sd38953, 18'sd59085, 18'sd66925
	};

	// second set, the one in use after reset
	localparam coef_t SET_B [`FIR_COEFS] = '{
		18'sd2817, 18'sd4060, 18'sd2289, -18'sd2373,
		-18'sd7348, -18'sd8574, -18'sd2772, 18'sd10263,
		18'sd26830, 18'sd40696, 18'sd46096
	};

	// both banks, indexed by bank number then coefficient
	coef_t bank [2][`FIR_COEFS];
	logic  active_bank;
	// decoded strobes, one per word format
	logic  write_hit;
	logic  mode_hit;

	assign write_hit = cfg_valid && (cfg_word.wr.tag == CFG_TAG_WRITE);
	assign mode_hit  = cfg_valid && (cfg_word.mode.tag == CFG_TAG_MODE);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `FIR_COEFS; i++) begin
				bank[BANK_A][i] <= SET_A[i];
				bank[BANK_B][i] <= SET_B[i];
			end
			active_bank <= BANK_B;
		end else if (write_hit) begin
			// stray indices are dropped
			if (cfg_word.wr.index < `FIR_COEFS) begin
				bank[cfg_word.wr.bank][cfg_word.wr.index] <= cfg_word.wr.value;
			end
		end else if (mode_hit) begin
			active_bank <= cfg_word.mode.bank_sel;
		end
	end

	// active bank straight to the multipliers
	always_comb begin
		for (int i = 0; i < `FIR_COEFS; i++) begin
			coefs.c[i] = bank[active_bank][i];
		end
	end

	// only indices 0 to 10 exist in either bank
	cfg_index_in_range: assert property (
		@(posedge clk) disable iff (reset)
		write_hit |-> (cfg_word.wr.index < `FIR_COEFS)
	) else $error("coefficient write to index %0d", cfg_word.wr.index);

endmodule

// File: source/fir_delay_line.sv
`timescale 1ns/1ps
`include "fir_params.svh"

module fir_delay_line (
	input  logic                    clk,
	input  logic                    reset,
	input  fir_sample_pkg::sample_t sample_in,
	input  logic                    sample_valid,
	output fir_sample_pkg::folded_t folded
);
	import fir_sample_pkg::*;

	// halved input on its way into tap 0
	sample_t                  half_in;
	// taps now and after the shift
	tap_vec_t                 taps;
	tap_vec_t                 taps_next;
	// folded sums of the shifted taps
	sample_t [`FIR_COEFS-1:0] pair_next;
	sample_t [`FIR_COEFS-1:0] pair_q;
	logic                     pair_valid;

	// sign bit repeated so tap pairs can be added with headroom
	assign half_in = {sample_in[`FIR_DATA_W-1], sample_in[`FIR_DATA_W-1:1]};

	// newest sample enters at the bottom, oldest drops off the top
	assign taps_next = {taps[`FIR_TAPS-2:0], half_in};

	// symmetric pairs share a coefficient
	always_comb begin
		for (int i = 0; i < `FIR_COEFS - 1; i++) begin
			pair_next[i] = taps_next[i] + taps_next[`FIR_TAPS-1-i];
		end
		// centre tap has no partner
		pair_next[`FIR_COEFS-1] = taps_next[`FIR_COEFS-1];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			taps       <= '0;
			pair_valid <= 1'b0;
		end else begin
			pair_valid <= sample_valid;
			if (sample_valid) begin
				taps <= taps_next;
			end
		end
	end

	// sums only move with a sample
	always_ff @(posedge clk) begin
		if (sample_valid) begin
			pair_q <= pair_next;
		end
	end

	assign folded.pair  = pair_q;
	assign folded.valid = pair_valid;

endmodule

// File: source/fir_mac_tree.sv
`timescale 1ns/1ps
`include "fir_params.svh"

module fir_mac_tree (
	input  logic                      clk,
	input  logic                      reset,
	input  fir_sample_pkg::folded_t   folded,
	input  fir_sample_pkg::coef_set_t coefs,
	output fir_sample_pkg::sample_t   y,
	output logic                      y_valid
);
	import fir_sample_pkg::*;

	// adder tree widths, odd counts carry the last term alone
	localparam int L2_N = (`FIR_COEFS + 1) / 2;
	localparam int L3_N = (L2_N + 1) / 2;

	// full products, 2s34
	prod_t   prod_full [`FIR_COEFS];
	// middle slices, registered
	sample_t prod_q [`FIR_COEFS];
	logic    prod_valid;
	// level-2 sums
	sample_t l2_next [L2_N];
	sample_t l2_q [L2_N];
	logic    l2_valid;
	// level-3 sums and their total
	sample_t l3 [L3_N];
	sample_t y_next;

	// 2s16 times 0s18
	always_comb begin
		for (int i = 0; i < `FIR_COEFS; i++) begin
			prod_full[i] = $signed(folded.pair[i]) * $signed(coefs.c[i]);
		end
	end

	always_comb begin
		for (int i = 0; i < L2_N; i++) begin
			if (2 * i + 1 < `FIR_COEFS) begin
				l2_next[i] = prod_q[2*i] + prod_q[2*i+1];
			end else begin
				l2_next[i] = prod_q[2*i];
			end
		end
	end

	// last two levels share one cycle
	always_comb begin
		for (int i = 0; i < L3_N; i++) begin
			if (2 * i + 1 < L2_N) begin
				l3[i] = l2_q[2*i] + l2_q[2*i+1];
			end else begin
				l3[i] = l2_q[2*i];
			end
		end
		y_next = '0;
		for (int i = 0; i < L3_N; i++) begin
			y_next = y_next + l3[i];
		end
	end

	// payload stages, advanced only by their valid
	always_ff @(posedge clk) begin
		if (folded.valid) begin
			for (int i = 0; i < `FIR_COEFS; i++) begin
				// drop the top sign bit and the low 17 fraction bits
				prod_q[i] <= prod_full[i][`FIR_PROD_W-2 -: `FIR_DATA_W];
			end
		end
		if (prod_valid) begin
			l2_q <= l2_next;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			prod_valid <= 1'b0;
			l2_valid   <= 1'b0;
			y_valid    <= 1'b0;
			y          <= '0;
		end else begin
			prod_valid <= folded.valid;
			l2_valid   <= prod_valid;
			y_valid    <= l2_valid;
			if (l2_valid) begin
				y <= y_next;
			end
		end
	end

	// every result traces back to a folded word three cycles earlier
	out_valid_has_source: assert property (
		@(posedge clk) disable iff (reset)
		y_valid |-> $past(folded.valid, 3)
	) else $error("y_valid without a matching folded sample");

endmodule

// File: source/fir_params.svh
`ifndef FIR_PARAMS_SVH
`define FIR_PARAMS_SVH

// delay line length
// odd so that one centre tap has no partner
`define FIR_TAPS 21

// one coefficient per tap pair plus the centre tap
`define FIR_COEFS 11

// width of samples, coefficients and every partial sum
`define FIR_DATA_W 18

// full signed product of two data words
`define FIR_PROD_W 36

// cycles from an accepted sample to its result
// delay line, products, level-2 sums, output register
`define FIR_LATENCY 4

`endif

// File: source/fir_sample_pkg.sv
`include "fir_params.svh"

package fir_sample_pkg;

	// 1s17 input, 2s16 after halving
	typedef logic signed [`FIR_DATA_W-1:0] sample_t;

	// fraction-only coefficient, 0s18
	typedef logic signed [`FIR_DATA_W-1:0] coef_t;

	// full product before the middle slice is taken
	typedef logic signed [`FIR_PROD_W-1:0] prod_t;

	// whole delay line, tap 0 is the newest sample
	typedef sample_t [`FIR_TAPS-1:0] tap_vec_t;

	// pair sums handed to the multiplier stage
	typedef struct packed {
		sample_t [`FIR_COEFS-1:0] pair;
		logic                     valid;
	} folded_t;

	// coefficients of whichever bank is active
	typedef struct packed {
		coef_t [`FIR_COEFS-1:0] c;
	} coef_set_t;

endpackage

// File: source/sine_filt_top.sv
`timescale 1ns/1ps

module sine_filt_top (
	input  logic                    clk,
	input  logic                    reset,
	input  fir_sample_pkg::sample_t sample_in,
	input  logic                    sample_valid,
	input  fir_cfg_pkg::cfg_word_u  cfg_word,
	input  logic                    cfg_valid,
	output fir_sample_pkg::sample_t y,
	output logic                    y_valid
);
	import fir_sample_pkg::*;

	// pair sums and their valid, one cycle after the sample
	folded_t   folded;
	// active bank
	coef_set_t coefs;

	fir_delay_line delay_i (
		.clk          (clk),
		.reset        (reset),
		.sample_in    (sample_in),
		.sample_valid (sample_valid),
		.folded       (folded)
	);

	// config traffic is expected only while the pipe is empty
	fir_coef_bank coef_i (
		.clk       (clk),
		.reset     (reset),
		.cfg_word  (cfg_word),
		.cfg_valid (cfg_valid),
		.coefs     (coefs)
	);

	fir_mac_tree mac_i (
		.clk     (clk),
		.reset   (reset),
		.folded  (folded),
		.coefs   (coefs),
		.y       (y),
		.y_valid (y_valid)
	);

endmodule

// File: tb/fir_ref_model.svh
`ifndef FIR_REF_MODEL_SVH
`define FIR_REF_MODEL_SVH

// input scaling ahead of the delay line, sign bit kept
function automatic sample_t halve(input sample_t s);
	return s >>> 1;
endfunction

// expected filter output for one history
// hist[0] is the newest halved sample
function automatic sample_t model_output(input tap_vec_t hist, input coef_set_t cset);
	sample_t                       pair;
	logic signed [`FIR_PROD_W-1:0] prod;
	sample_t                       acc;
	acc = '0;
	for (int k = 0; k < `FIR_COEFS; k++) begin
		// outer taps fold onto one coefficient, centre stands alone
		if (k == `FIR_COEFS - 1) begin
			pair = $signed(hist[k]);
		end else begin
			pair = $signed(hist[k]) + $signed(hist[`FIR_TAPS-1-k]);
		end
		prod = $signed(pair) * $signed(cset.c[k]);
		// keep bits 34 to 17, every sum wraps at 18 bits
		acc = acc + prod[`FIR_PROD_W-2 -: `FIR_DATA_W];
	end
	return acc;
endfunction

`endif

// File: tb/sine_filt_tb.sv
`timescale 1ns/1ps
`include "fir_params.svh"

module sine_filt_tb;
	import fir_sample_pkg::*;
	import fir_cfg_pkg::*;

	`include "fir_ref_model.svh"

	// about 700 cycles of stimulus plus a generous margin
	localparam int MAX_CYCLES = 2000;

	// one expected result and the cycle it falls due
	typedef struct packed {
		int      due;
		sample_t y;
	} expect_t;

	logic      clk = 1'b0;
	logic      reset;
	sample_t   sample_in;
	logic      sample_valid;
	cfg_word_u cfg_word;
	logic      cfg_valid;
	sample_t   y;
	logic      y_valid;

	// reference copies of the banks and the halved history
	coef_set_t bank_model [2];
	logic      active_model;
	tap_vec_t  hist;
	expect_t   sb_q [$];
	int        cyc = 0;
	int        wd_count = 0;
	int        n_sent = 0;
	int        n_checked = 0;
	// head of the queue as seen by the assertions
	logic      due_now = 1'b0;
	sample_t   exp_y = '0;
	logic      result_seen = 1'b0;
	logic      started = 1'b0;
	string     test_name = "reset";

	sine_filt_top dut_i (
		.clk          (clk),
		.reset        (reset),
		.sample_in    (sample_in),
		.sample_valid (sample_valid),
		.cfg_word     (cfg_word),
		.cfg_valid    (cfg_valid),
		.y            (y),
		.y_valid      (y_valid)
	);

	initial begin
		forever #10 clk = ~clk;
	end

	// reset contents of bank A and bank B with outer taps first
	function automatic coef_set_t reset_coefs(input logic b);
		int        set_a [`FIR_COEFS] = '{4090, 5895, 3323, -3446, -10669, -12449,
			-4025, 14901, 38953, 59085, 66925};
		int        set_b [`FIR_COEFS] = '{2817, 4060, 2289, -2373, -7348, -8574,
			-2772, 10263, 26830, 40696, 46096};
		coef_set_t s;
		for (int k = 0; k < `FIR_COEFS; k++) begin
			s.c[k] = coef_t'(b ? set_b[k] : set_a[k]);
		end
		return s;
	endfunction

	// full-scale samples whose signs follow the coefficient signs
	// coefficients 3 to 6 are negative in both sets
	function automatic sample_t wrap_pattern(input int n);
		int idx;
		idx = (n < `FIR_TAPS - 1 - n) ? n : `FIR_TAPS - 1 - n;
		return (idx >= 3 && idx <= 6) ? 18'sh20000 : 18'sh1ffff;
	endfunction

	task automatic report_value_error(input string what, input int expected, input int actual);
		$display("** Error [%s] %s expected %0d actual %0d", test_name, what, expected, actual);
		$display("SIMULATION FAILED");
		$fatal(1, "value mismatch");
	endtask

	// scoreboard updated at the edge where the DUT samples its inputs
	always @(posedge clk) begin
		expect_t e;
		started <= 1'b1;
		if (reset) begin
			sb_q.delete();
			hist = '0;
			bank_model[BANK_A] = reset_coefs(BANK_A);
			bank_model[BANK_B] = reset_coefs(BANK_B);
			active_model = BANK_B;
			cyc = 0;
			due_now <= 1'b0;
			result_seen <= 1'b0;
		end else begin
			cyc = cyc + 1;
			// head was due at this edge
			if (due_now) begin
				void'(sb_q.pop_front());
				n_checked++;
				result_seen <= 1'b1;
			end
			if (cfg_valid) begin
				if (cfg_word.wr.tag == CFG_TAG_WRITE && cfg_word.wr.index < `FIR_COEFS) begin
					bank_model[cfg_word.wr.bank].c[cfg_word.wr.index] = cfg_word.wr.value;
				end else if (cfg_word.mode.tag == CFG_TAG_MODE) begin
					active_model = cfg_word.mode.bank_sel;
				end
			end
			if (sample_valid) begin
				hist = {hist[`FIR_TAPS-2:0], halve(sample_in)};
				e.due = cyc + `FIR_LATENCY;
				e.y = model_output(hist, bank_model[active_model]);
				sb_q.push_back(e);
				n_sent++;
			end
			// looks one edge ahead
			if (sb_q.size() != 0) begin
				due_now <= (sb_q[0].due == cyc + 1);
				exp_y <= sb_q[0].y;
			end else begin
				due_now <= 1'b0;
			end
		end
	end

	y_valid_on_time: assert property (@(posedge clk) started |-> (y_valid == due_now))
		else report_value_error("y_valid", $sampled(due_now), $sampled(y_valid));

	y_matches_model: assert property (@(posedge clk) started && y_valid |-> (y == exp_y))
		else report_value_error("y", $sampled(exp_y), $sampled(y));

	// output register holds zero until the first result
	y_zero_before_result: assert property (
		@(posedge clk) started && !result_seen && !due_now |-> (y == '0)
	) else report_value_error("y before first result", 0, $sampled(y));

	always @(posedge clk) begin
		wd_count = wd_count + 1;
		if (wd_count >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("SIMULATION FAILED");
			$fatal(1, "watchdog expired");
		end
	end

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			sample_valid = 1'b0;
			cfg_valid = 1'b0;
		end
	endtask

	task automatic send_sample(input sample_t s);
		@(negedge clk);
		sample_in = s;
		sample_valid = 1'b1;
	endtask

	task automatic send_write(input logic bank, input int index, input sample_t value);
		cfg_word_u w;
		w = '0;
		w.wr.tag = CFG_TAG_WRITE;
		w.wr.bank = bank;
		w.wr.index = 4'(index);
		w.wr.value = value;
		@(negedge clk);
		cfg_word = w;
		cfg_valid = 1'b1;
	endtask

	task automatic send_mode(input logic bank);
		cfg_word_u w;
		w = '0;
		w.mode.tag = CFG_TAG_MODE;
		w.mode.bank_sel = bank;
		@(negedge clk);
		cfg_word = w;
		cfg_valid = 1'b1;
	endtask

	// stop driving and wait for every outstanding result
	task automatic wait_drain();
		idle(1);
		while (sb_q.size() != 0) begin
			@(negedge clk);
		end
		idle(5);
	endtask

	// one full-scale sample and then zeros until it leaves the delay line
	task automatic run_impulse();
		send_sample(18'sh1ffff);
		repeat (`FIR_TAPS - 1) send_sample('0);
		wait_drain();
	endtask

	initial begin
		sample_t s;
		void'($urandom(32'h596d_1cc6));
		reset = 1'b1;
		sample_in = '0;
		sample_valid = 1'b0;
		cfg_word = '0;
		cfg_valid = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		idle(6);
		test_name = "impulse_bank_b";
		run_impulse();
		test_name = "bank_switch";
		send_mode(BANK_A);
		idle(5);
		run_impulse();
		// new centre value in bank A which is now active
		test_name = "coef_write";
		send_write(BANK_A, `FIR_COEFS - 1, 18'sd70000);
		idle(5);
		run_impulse();
		// first 21 samples drive the sum past full scale
		test_name = "back_to_back";
		for (int n = 0; n < 300; n++) begin
			s = (n < `FIR_TAPS) ? wrap_pattern(n) : sample_t'($urandom);
			send_sample(s);
		end
		wait_drain();
		test_name = "random_gaps";
		for (int n = 0; n < 200; n++) begin
			s = sample_t'($urandom);
			if ($urandom_range(2) == 0) begin
				idle(1);
			end else begin
				send_sample(s);
			end
		end
		wait_drain();
		if (n_checked == n_sent && n_sent > 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("only %0d of %0d results arrived", n_checked, n_sent);
			$display("SIMULATION FAILED");
			$fatal(1, "missing results");
		end
	end

endmodule

// File: vlog.f
+incdir+source
+incdir+tb
source/fir_sample_pkg.sv
source/fir_cfg_pkg.sv
source/fir_delay_line.sv
source/fir_coef_bank.sv
source/fir_mac_tree.sv
source/sine_filt_top.sv
tb/sine_filt_tb.sv
